// File: tv1_pkg.sv
// Background-only TV-1 model: sprites, VRAM bus and CPU wait states are not present
package tv1_pkg;

  ////////////////////////////////////////
  // Video timing

  typedef logic [8:0]  coord_t;     // Row or column position
  typedef logic [3:0]  color_t;     // Palette index
  typedef logic [12:0] cpu_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  bgm_addr_t;  // 32-bit BGM word
  typedef logic [9:0]  chr_addr_t;
  typedef logic [23:0] rgb_t;       // {R, G, B}

  localparam coord_t NUM_COLS = 9'd260;
  localparam coord_t NUM_ROWS = 9'd263;

  // Render window of 208 x 232
  localparam coord_t FIRST_ROW_RENDER = 9'd16;
  localparam coord_t LAST_ROW_RENDER  = 9'd247;
  localparam coord_t FIRST_COL_RENDER = 9'd23;
  localparam coord_t LAST_COL_RENDER  = 9'd230;

  localparam coord_t FIRST_ROW_VSYNC = 9'd257;
  localparam coord_t LAST_ROW_VSYNC  = 9'd259;
  localparam coord_t FIRST_COL_HSYNC = 9'd240;
  localparam coord_t LAST_COL_HSYNC  = 9'd259;

  localparam color_t BORDER_COLOR = 4'd1;  // Black in both palettes

  ////////////////////////////////////////
  // CPU map and register fields

  localparam logic [3:0] BGM_PAGE = 4'b1000;  // 1000h-11FFh
  localparam logic [3:0] REG_PAGE = 4'b1010;  // 1400h-15FFh

  localparam logic [1:0] REG_MODE   = 2'd0;
  localparam logic [1:0] REG_BM_CLR = 2'd1;
  localparam logic [1:0] REG_WIN    = 2'd2;
  localparam logic [1:0] REG_CH_CLR = 2'd3;

  localparam int BIT_BM_ENA   = 0;
  localparam int BIT_BM_LORES = 1;
  localparam int BIT_BM_INVX  = 6;
  localparam int BIT_BM_INVY  = 7;

  typedef enum logic {
    PALETTE_RGB,
    PALETTE_RF
  } palette_t;

  typedef struct packed {
    logic   bm_ena;
    logic   bm_lores;
    logic   bm_invx;
    logic   bm_invy;
    color_t bm_clr_bg;
    color_t bm_clr_fg;
    color_t ch_clr_bg;
    color_t ch_clr_fg;
    logic [3:0] bm_xmax;  // Window split in 16-pixel units
    logic [3:0] bm_ymax;
  } vid_ctrl_t;

  typedef struct packed {
    coord_t row;
    coord_t col;
    logic   render;
    logic   hs;
    logic   vs;
    logic   vbl;
  } beam_t;

  typedef struct packed {
    beam_t  beam;
    logic   tile_load;
    byte_t  pat;   // Bit 0 is shown first
    color_t fgc;
    color_t bgc;
  } bg_word_t;

  typedef struct packed {
    logic      sel;
    bgm_addr_t addr;
    logic [1:0] lane;
    logic      we;
    byte_t     wdata;
  } bgm_cpu_t;

endpackage

// File: tv1_video_counter.sv
// Advances only on CE; the flags lag row/col by one CE tick and describe the position just left
`timescale 1ns/1ns

module tv1_video_counter (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            CE,
  output tv1_pkg::beam_t  beam
);

  import tv1_pkg::*;

  coord_t row, col;
  coord_t row_next, col_next;
  logic   render_row, render_col;
  logic   render_q, hs_q, vs_q, vbl_q;

  always_comb begin
    row_next = row;
    col_next = col + 9'd1;
    if (col == NUM_COLS - 9'd1) begin  // End of line
      col_next = '0;
      if (row == NUM_ROWS - 9'd1)
        row_next = '0;
      else
        row_next = row + 9'd1;
    end
  end

  assign render_row = (row >= FIRST_ROW_RENDER) && (row <= LAST_ROW_RENDER);
  assign render_col = (col >= FIRST_COL_RENDER) && (col <= LAST_COL_RENDER);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      row      <= '0;
      col      <= '0;
      render_q <= 1'b0;
      hs_q     <= 1'b0;
      vs_q     <= 1'b0;
      vbl_q    <= 1'b0;
    end else if (CE) begin
      row      <= row_next;
      col      <= col_next;
      // Flags from the old position
      render_q <= render_row && render_col;
      hs_q     <= (col >= FIRST_COL_HSYNC) && (col <= LAST_COL_HSYNC);
      vs_q     <= (row >= FIRST_ROW_VSYNC) && (row <= LAST_ROW_VSYNC);
      vbl_q    <= !render_row;
    end
  end

  always_comb begin
    beam.row    = row;
    beam.col    = col;
    beam.render = render_q;
    beam.hs     = hs_q;
    beam.vs     = vs_q;
    beam.vbl    = vbl_q;
  end

endmodule

// File: tv1_cpu_bus.sv
// Plain strobe bus without wait states; reads must be held a few CE ticks before DB_O is valid
`timescale 1ns/1ns

module tv1_cpu_bus (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                CE,
  input  logic                CSB,
  input  logic                RDB,
  input  logic                WRB,
  input  tv1_pkg::cpu_addr_t  A,
  input  tv1_pkg::byte_t      DB_I,
  input  tv1_pkg::byte_t      bgm_cpu_rdata,
  output tv1_pkg::byte_t      DB_O,
  output logic                DB_OE,
  output tv1_pkg::vid_ctrl_t  ctrl,
  output tv1_pkg::bgm_cpu_t   bgm_cpu
);

  import tv1_pkg::*;

  logic  sel_bgm, sel_reg;
  logic  cpu_rd, cpu_wr;
  byte_t regs [4];
  byte_t reg_rdata;
  byte_t rdata_q;

  ////////////////////////////////////////
  // Address decode

  assign sel_bgm = !CSB && (A[12:9] == BGM_PAGE);
  assign sel_reg = !CSB && (A[12:9] == REG_PAGE);
  assign cpu_rd  = !CSB && !RDB;
  assign cpu_wr  = !CSB && !WRB;

  ////////////////////////////////////////
  // MMIO registers mirrored through the page

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++)
        regs[i] <= '0;
    end else if (sel_reg && cpu_wr) begin
      regs[A[1:0]] <= DB_I;
    end
  end

  assign reg_rdata = regs[A[1:0]];

  // Read data refreshed every CE tick while the read is held
  always_ff @(posedge CLK) begin
    if (!rst_n)
      rdata_q <= '0;
    else if (CE && cpu_rd) begin
      if (sel_bgm)
        rdata_q <= bgm_cpu_rdata;
      else if (sel_reg)
        rdata_q <= reg_rdata;
      else
        rdata_q <= '0;  // Unmapped
    end
  end

  assign DB_O  = rdata_q;
  assign DB_OE = cpu_rd;

  // BGM request; the fetch stage picks the slot
  always_comb begin
    bgm_cpu.sel   = sel_bgm && (cpu_rd || cpu_wr);
    bgm_cpu.addr  = A[8:2];
    bgm_cpu.lane  = A[1:0];
    bgm_cpu.we    = cpu_wr;
    bgm_cpu.wdata = DB_I;
  end

  ////////////////////////////////////////
  // Register fields

  always_comb begin
    ctrl.bm_ena    = regs[REG_MODE][BIT_BM_ENA];
    ctrl.bm_lores  = regs[REG_MODE][BIT_BM_LORES];
    ctrl.bm_invx   = regs[REG_MODE][BIT_BM_INVX];
    ctrl.bm_invy   = regs[REG_MODE][BIT_BM_INVY];
    ctrl.bm_clr_bg = regs[REG_BM_CLR][3:0];
    ctrl.bm_clr_fg = regs[REG_BM_CLR][7:4];
    ctrl.bm_xmax   = regs[REG_WIN][3:0];
    ctrl.bm_ymax   = regs[REG_WIN][7:4];
    ctrl.ch_clr_bg = regs[REG_CH_CLR][3:0];
    ctrl.ch_clr_fg = regs[REG_CH_CLR][7:4];
  end

endmodule

// File: tv1_bg_fetch.sv
// Expects CE at most every other clock, since the CPU takes the BGM port on the clock after CE
`timescale 1ns/1ns

module tv1_bg_fetch (
  input  logic                CLK,
  input  logic                CE,
  input  tv1_pkg::beam_t      beam_in,
  input  tv1_pkg::vid_ctrl_t  ctrl,
  input  tv1_pkg::bgm_cpu_t   bgm_cpu,
  input  tv1_pkg::chr_addr_t  rom_addr,
  input  tv1_pkg::byte_t      rom_data,
  input  logic                rom_valid,
  output tv1_pkg::byte_t      bgm_cpu_rdata,
  output tv1_pkg::bg_word_t   word_out
);

  import tv1_pkg::*;

  logic [31:0] bgm [128];
  byte_t       chr [1024];

  logic        ce_d, cpu_slot, cpu_slot_d;
  bgm_addr_t   bgm_addr;
  logic [31:0] bgm_rbuf, bgm_vid;
  byte_t       tile_byte, chr_rbuf;
  logic [4:0]  tx, ty;
  logic        xwin, ywin, is_ch, is_bm;
  logic [2:0]  hi_sel, lo_sel;
  logic [1:0]  hi_bits;
  logic [3:0]  lo_nib;
  byte_t       ch_pat, bm_pat, src_pat, pat_rev;
  color_t      bm_fgc;

  assign tx = beam_in.col[7:3];
  assign ty = beam_in.row[7:3];

  ////////////////////////////////////////
  // BGM with one port shared by CPU and video

  always_ff @(posedge CLK) begin
    ce_d       <= CE;
    cpu_slot_d <= cpu_slot;
  end

  assign cpu_slot = bgm_cpu.sel && ce_d;
  assign bgm_addr = cpu_slot ? bgm_cpu.addr : {ty[4:1], tx[4:2]};

  always_ff @(posedge CLK) begin
    bgm_rbuf <= bgm[bgm_addr];
    if (cpu_slot && bgm_cpu.we)
      bgm[bgm_addr][{bgm_cpu.lane, 3'b000} +: 8] <= bgm_cpu.wdata;
  end

  // Steer the read word to its owner
  always_ff @(posedge CLK) begin
    if (cpu_slot_d)
      bgm_cpu_rdata <= bgm_rbuf[{bgm_cpu.lane, 3'b000} +: 8];
    else
      bgm_vid <= bgm_rbuf;
  end

  assign tile_byte = bgm_vid[{tx[1:0], 3'b000} +: 8];

  ////////////////////////////////////////
  // CHR ROM

  always_ff @(posedge CLK) begin
    if (rom_valid)
      chr[rom_addr] <= rom_data;
    chr_rbuf <= chr[{tile_byte[6:0], beam_in.row[2:0]}];
  end

  ////////////////////////////////////////
  // Pattern select

  assign xwin  = (tx[4:1] < ctrl.bm_xmax) ^ ctrl.bm_invx;
  assign ywin  = (ty[4:1] < ctrl.bm_ymax) ^ ctrl.bm_invy;
  assign is_ch = xwin && ywin;
  assign is_bm = ctrl.bm_ena && !is_ch;

  assign hi_sel  = {~beam_in.row[3:2], 1'b0};  // Two bits per 4 rows
  assign lo_sel  = {~beam_in.row[3], 2'b00};    // One nibble per 8 rows
  assign hi_bits = tile_byte[hi_sel +: 2];
  assign lo_nib  = tile_byte[lo_sel +: 4];

  assign ch_pat = ty[0] ? 8'h00 : {2'b00, chr_rbuf[7:2]};  // Odd tile rows blank

  always_comb begin
    bm_pat = '0;
    bm_fgc = ctrl.bm_clr_fg;
    if (is_bm) begin
      if (ctrl.bm_lores) begin
        if (lo_nib != 4'd0) begin  // Zero stays background
          bm_pat = 8'hFF;
          bm_fgc = lo_nib;
        end
      end else begin
        bm_pat = {{4{hi_bits[1]}}, {4{hi_bits[0]}}};
      end
    end
    src_pat = is_ch ? ch_pat : bm_pat;
    for (int i = 0; i < 8; i++)
      pat_rev[7 - i] = src_pat[i];
  end

  always_ff @(posedge CLK) begin
    if (CE) begin
      word_out.beam      <= beam_in;
      word_out.tile_load <= (beam_in.col[2:0] == 3'd4);
      word_out.pat       <= pat_rev;
      word_out.fgc       <= is_ch ? ctrl.ch_clr_fg : bm_fgc;
      word_out.bgc       <= is_ch ? ctrl.ch_clr_bg : ctrl.bm_clr_bg;
    end
  end

endmodule

// File: tv1_bg_shifter.sv
// Palette tables are fixed; outputs leave registered and aligned, two CE ticks after the counter
`timescale 1ns/1ns

module tv1_bg_shifter (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               CE,
  input  tv1_pkg::bg_word_t  word_in,
  input  tv1_pkg::palette_t  cfg_palette,
  output logic               DE,
  output logic               HS,
  output logic               VS,
  output logic               VBL,
  output tv1_pkg::rgb_t      RGB
);

  import tv1_pkg::*;

  byte_t  shift_q;
  color_t fgc_q, bgc_q;
  color_t px, pd;
  rgb_t   cg;

  always_ff @(posedge CLK) begin
    if (CE) begin
      if (word_in.tile_load) begin
        shift_q <= word_in.pat;
        fgc_q   <= word_in.fgc;
        bgc_q   <= word_in.bgc;
      end else begin
        shift_q <= {1'b0, shift_q[7:1]};
      end
    end
  end

  assign px = shift_q[0] ? fgc_q : bgc_q;
  assign pd = word_in.beam.render ? px : BORDER_COLOR;  // Black borders

  ////////////////////////////////////////
  // Colour lookup

  always_comb begin
    if (cfg_palette == PALETTE_RGB) begin
      case (pd)
        4'd0:  cg = 24'h0000A0;
        4'd1:  cg = 24'h000000;
        4'd2:  cg = 24'h0000F5;
        4'd3:  cg = 24'hA000EB;
        4'd4:  cg = 24'h00F500;
        4'd5:  cg = 24'h96EB96;
        4'd6:  cg = 24'h00EBEB;
        4'd7:  cg = 24'h00A000;
        4'd8:  cg = 24'hF50000;
        4'd9:  cg = 24'hEBA000;
        4'd10: cg = 24'hEB00EB;
        4'd11: cg = 24'hEB9696;
        4'd12: cg = 24'hEBEB00;
        4'd13: cg = 24'hA0A000;
        4'd14: cg = 24'h969696;
        default: cg = 24'hE1E1E1;
      endcase
    end else begin  // RF modulator levels
      case (pd)
        4'd0:  cg = 24'h005A9C;
        4'd1:  cg = 24'h000000;
        4'd2:  cg = 24'h3A94FF;
        4'd3:  cg = 24'h0000FF;
        4'd4:  cg = 24'h10D600;
        4'd5:  cg = 24'h42FF10;
        4'd6:  cg = 24'h7BE6C5;
        4'd7:  cg = 24'h00AD00;
        4'd8:  cg = 24'hFF2994;
        4'd9:  cg = 24'hFF3110;
        4'd10: cg = 24'hFF3AFF;
        4'd11: cg = 24'hEF9CFF;
        4'd12: cg = 24'hFFCE21;
        4'd13: cg = 24'h4A7B10;
        4'd14: cg = 24'hA594A5;
        default: cg = 24'hFFFFFF;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      DE  <= 1'b0;
      HS  <= 1'b0;
      VS  <= 1'b0;
      VBL <= 1'b0;
    end else if (CE) begin
      DE  <= word_in.beam.render;
      HS  <= word_in.beam.hs;
      VS  <= word_in.beam.vs;
      VBL <= word_in.beam.vbl;
    end
  end

  always_ff @(posedge CLK) begin
    if (CE)
      RGB <= cg;
  end

endmodule

// File: tv1_top.sv
// Background half of the TV-1 only; ROM init writes the CHR ROM, one byte per strobed clock
`timescale 1ns/1ns

module tv1_top (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                CE,       // Pixel strobe

  input  tv1_pkg::chr_addr_t  ROMINIT_ADDR,
  input  tv1_pkg::byte_t      ROMINIT_DATA,
  input  logic                ROMINIT_VALID,

  input  tv1_pkg::palette_t   cfg_palette,

  input  tv1_pkg::cpu_addr_t  A,
  input  tv1_pkg::byte_t      DB_I,
  output tv1_pkg::byte_t      DB_O,
  output logic                DB_OE,
  input  logic                RDB,
  input  logic                WRB,
  input  logic                CSB,

  output logic                VBL,
  output logic                DE,
  output logic                HS,
  output logic                VS,
  output tv1_pkg::rgb_t       RGB
);

  import tv1_pkg::*;

  beam_t     beam;
  vid_ctrl_t ctrl;
  bgm_cpu_t  bgm_cpu;
  byte_t     bgm_cpu_rdata;
  bg_word_t  bg_word;

  tv1_video_counter u_counter (
    .CLK   (CLK),
    .rst_n (rst_n),
    .CE    (CE),
    .beam  (beam)
  );

  tv1_cpu_bus u_cpu_bus (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .CE            (CE),
    .CSB           (CSB),
    .RDB           (RDB),
    .WRB           (WRB),
    .A             (A),
    .DB_I          (DB_I),
    .bgm_cpu_rdata (bgm_cpu_rdata),
    .DB_O          (DB_O),
    .DB_OE         (DB_OE),
    .ctrl          (ctrl),
    .bgm_cpu       (bgm_cpu)
  );

  tv1_bg_fetch u_fetch (
    .CLK           (CLK),
    .CE            (CE),
    .beam_in       (beam),
    .ctrl          (ctrl),
    .bgm_cpu       (bgm_cpu),
    .rom_addr      (ROMINIT_ADDR),
    .rom_data      (ROMINIT_DATA),
    .rom_valid     (ROMINIT_VALID),
    .bgm_cpu_rdata (bgm_cpu_rdata),
    .word_out      (bg_word)
  );

  tv1_bg_shifter u_shifter (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .CE          (CE),
    .word_in     (bg_word),
    .cfg_palette (cfg_palette),
    .DE          (DE),
    .HS          (HS),
    .VS          (VS),
    .VBL         (VBL),
    .RGB         (RGB)
  );

endmodule

// File: tb_tv1_checks.svh
// Included inside tb_tv1 after tv1_pkg is imported; palette tables must match the fixed video colours
`ifndef TB_TV1_CHECKS_SVH
`define TB_TV1_CHECKS_SVH

  // Entry 15 first
  localparam logic [16*24-1:0] PAL_RGB_TABLE = {
    24'hE1E1E1, 24'h969696, 24'hA0A000, 24'hEBEB00,
    24'hEB9696, 24'hEB00EB, 24'hEBA000, 24'hF50000,
    24'h00A000, 24'h00EBEB, 24'h96EB96, 24'h00F500,
    24'hA000EB, 24'h0000F5, 24'h000000, 24'h0000A0
  };

  localparam logic [16*24-1:0] PAL_RF_TABLE = {
    24'hFFFFFF, 24'hA594A5, 24'h4A7B10, 24'hFFCE21,
    24'hEF9CFF, 24'hFF3AFF, 24'hFF3110, 24'hFF2994,
    24'h00AD00, 24'h7BE6C5, 24'h42FF10, 24'h10D600,
    24'h0000FF, 24'h3A94FF, 24'h000000, 24'h005A9C
  };

  function automatic rgb_t palette_color(input palette_t pal, input color_t idx);
    if (pal == PALETTE_RGB)
      return PAL_RGB_TABLE[idx * 24 +: 24];
    return PAL_RF_TABLE[idx * 24 +: 24];
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
    if (actual !== expected)
      report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %h actual %h",
                               $time, name, expected, actual));
  endtask

  task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
    if (actual !== expected)
      report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %h actual %h",
                               $time, name, expected, actual));
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected)
      report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %0d actual %0d",
                               $time, name, expected, actual));
  endtask

`endif

// File: tb_tv1.sv
// Needs tv1_stim.txt in the project root; CE is every other clock; frame checks take whole frames
`timescale 1ns/1ns

module tb_tv1;

  import tv1_pkg::*;

  // One stim line with values in hex
  typedef struct packed {
    byte_t       op;     // Command letter
    logic [15:0] addr;
    logic [15:0] count;
    logic [7:0]  mode;
    byte_t       data;
  } stim_cmd_t;

  localparam int FRAME_CLOCKS = 2 * int'(NUM_COLS) * int'(NUM_ROWS);

  logic      CLK, rst_n, CE;
  chr_addr_t ROMINIT_ADDR;
  byte_t     ROMINIT_DATA;
  logic      ROMINIT_VALID;
  palette_t  cfg_palette;
  cpu_addr_t A;
  byte_t     DB_I, DB_O;
  logic      DB_OE, RDB, WRB, CSB;
  logic      VBL, DE, HS, VS;
  rgb_t      RGB;

  stim_cmd_t   cmds[$];
  byte_t       bgm_model [512];  // Bytes last written to BGM
  logic [31:0] rng_state;
  logic        ce_seen;          // DUT saw CE at the last rising edge
  int          cycles, cycle_limit;
  int          de_cnt, hs_cnt, de_lines, vs_lines, frames_timed;
  logic        hs_prev, vs_prev;

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  `include "tb_tv1_checks.svh"

  tv1_top UUT (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .CE            (CE),
    .ROMINIT_ADDR  (ROMINIT_ADDR),
    .ROMINIT_DATA  (ROMINIT_DATA),
    .ROMINIT_VALID (ROMINIT_VALID),
    .cfg_palette   (cfg_palette),
    .A             (A),
    .DB_I          (DB_I),
    .DB_O          (DB_O),
    .DB_OE         (DB_OE),
    .RDB           (RDB),
    .WRB           (WRB),
    .CSB           (CSB),
    .VBL           (VBL),
    .DE            (DE),
    .HS            (HS),
    .VS            (VS),
    .RGB           (RGB)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    CE      <= ~CE;  // Pixel strobe every other clock
    ce_seen <= CE;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
      report_failure($sformatf("Timeout after %0d clocks, the stim commands did not finish",
                               cycles));
  end

  ////////////////////////////////////////
  // Video timing monitor

  always @(negedge CLK) begin
    if (!rst_n) begin
      de_cnt   = 0;
      hs_cnt   = 0;
      de_lines = 0;
      vs_lines = 0;
      hs_prev  = 1'b0;
      vs_prev  = 1'b0;
    end else if (ce_seen) begin
      if (DE)
        de_cnt++;
      if (HS)
        hs_cnt++;
      if (HS && !hs_prev) begin  // New sync pulse closes the line
        if (VS)
          vs_lines++;
        check_count("VBL on a line without DE", VBL, (de_cnt == 0));
        if (de_cnt != 0) begin
          check_count("DE ticks per line", de_cnt, 208);
          de_lines++;
        end
        de_cnt = 0;
      end
      if (!HS && hs_prev) begin
        check_count("HS ticks per line", hs_cnt, 20);
        hs_cnt = 0;
      end
      if (!VS && vs_prev) begin
        check_count("DE lines per frame", de_lines, 232);
        check_count("VS lines per frame", vs_lines, 3);
        de_lines = 0;
        vs_lines = 0;
        frames_timed++;
      end
      hs_prev = HS;
      vs_prev = VS;
    end
  end

  ////////////////////////////////////////
  // Bus and ROM tasks

  task automatic idle_random();
    rng_state = xorshift32(rng_state);
    repeat (rng_state[1:0]) @(posedge CLK);
  endtask

  task automatic cpu_write(input cpu_addr_t addr, input byte_t data);
    @(posedge CLK);
    A    <= addr;
    DB_I <= data;
    CSB  <= 1'b0;
    WRB  <= 1'b0;
    repeat (2) @(posedge CLK);  // Covers one BGM slot
    CSB <= 1'b1;
    WRB <= 1'b1;
    idle_random();
  endtask

  task automatic cpu_read(input cpu_addr_t addr, output byte_t data);
    int ticks;
    ticks = 0;
    @(posedge CLK);
    A   <= addr;
    CSB <= 1'b0;
    RDB <= 1'b0;
    while (ticks < 4) begin
      @(posedge CLK);
      if (CE)
        ticks++;
    end
    @(negedge CLK);
    check_count("DB_OE during read", DB_OE, 1);
    data = DB_O;
    @(posedge CLK);
    CSB <= 1'b1;
    RDB <= 1'b1;
    @(negedge CLK);
    check_count("DB_OE after read", DB_OE, 0);
    idle_random();
  endtask

  task automatic rom_fill(input byte_t data);
    for (int i = 0; i < 1024; i++) begin
      @(posedge CLK);
      ROMINIT_ADDR  <= chr_addr_t'(i);
      ROMINIT_DATA  <= data;
      ROMINIT_VALID <= 1'b1;
    end
    @(posedge CLK);
    ROMINIT_VALID <= 1'b0;
  endtask

  task automatic set_palette(input palette_t pal);
    @(posedge CLK);
    cfg_palette <= pal;
    @(posedge CLK);
  endtask

  // One whole frame from VS fall to VS fall
  task automatic frame_check(input color_t ca, input color_t cb);
    rgb_t pa, pb, pborder;
    logic vs_last, in_frame, done, seen_a, seen_b;
    pa       = palette_color(cfg_palette, ca);
    pb       = palette_color(cfg_palette, cb);
    pborder  = palette_color(cfg_palette, BORDER_COLOR);
    vs_last  = 1'b0;
    in_frame = 1'b0;
    done     = 1'b0;
    seen_a   = 1'b0;
    seen_b   = 1'b0;
    while (!done) begin
      @(negedge CLK);
      if (ce_seen) begin
        if (vs_last && !VS) begin
          if (in_frame)
            done = 1'b1;
          else
            in_frame = 1'b1;
        end
        vs_last = VS;
        if (in_frame && !done) begin
          if (!DE) begin
            check_rgb("RGB outside DE", RGB, pborder);
          end else begin
            if (RGB === pa)
              seen_a = 1'b1;
            if (RGB === pb)
              seen_b = 1'b1;
            if (RGB !== pa && RGB !== pb)
              check_rgb("RGB inside DE", RGB, pa);
          end
        end
      end
    end
    if (!seen_a || !seen_b)
      report_failure($sformatf("Colour %h or %h never appeared inside DE", ca, cb));
  endtask

  ////////////////////////////////////////
  // Stim file

  task automatic load_stim();
    int             fd, code;
    logic [63:0]    word;
    logic [1023:0]  rest;
    logic [15:0]    f_addr, f_count;
    logic [7:0]     f_mode, f_data;
    logic           done;
    stim_cmd_t      c;
    fd = $fopen("tv1_stim.txt", "r");
    if (fd == 0)
      report_failure("Cannot open tv1_stim.txt for reading");
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", word);
      if (code != 1) begin
        done = 1'b1;
      end else if (word[7:0] == "#") begin
        code = $fgets(rest, fd);  // Skip comment text
      end else begin
        code = $fscanf(fd, "%h %h %h %h", f_addr, f_count, f_mode, f_data);
        if (code != 4)
          report_failure($sformatf("Stim line for command %s is incomplete", word[7:0]));
        c.op    = word[7:0];
        c.addr  = f_addr;
        c.count = f_count;
        c.mode  = f_mode;
        c.data  = f_data;
        cmds.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  function automatic int run_budget();
    int total;
    total = 2000;
    for (int i = 0; i < cmds.size(); i++) begin
      case (cmds[i].op)
        "F":      total += 3 * FRAME_CLOCKS;
        "R":      total += 1100;
        "B", "Q": total += 24 * int'(cmds[i].count);
        default:  total += 24;
      endcase
    end
    return total;
  endfunction

  task automatic run_cmd(input stim_cmd_t c);
    byte_t     value, got;
    cpu_addr_t addr;
    case (c.op)
      "R": rom_fill(c.data);
      "W": cpu_write(cpu_addr_t'(c.addr), c.data);
      "B": begin
        for (int i = 0; i < int'(c.count); i++) begin
          addr  = cpu_addr_t'(c.addr + i);
          value = c.data;
          if (c.mode[0]) begin
            rng_state = xorshift32(rng_state);
            value     = rng_state[7:0];
          end
          bgm_model[addr[8:0]] = value;
          cpu_write(addr, value);
        end
      end
      "Q": begin
        for (int i = 0; i < int'(c.count); i++) begin
          addr  = cpu_addr_t'(c.addr + i);
          value = c.mode[0] ? bgm_model[addr[8:0]] : c.data;
          cpu_read(addr, got);
          check_byte($sformatf("DB_O at %h", addr), got, value);
        end
      end
      "P": set_palette(palette_t'(c.mode[0]));
      "F": frame_check(c.data[3:0], c.mode[3:0]);
      default: report_failure($sformatf("Unknown stim command %s", c.op));
    endcase
  endtask

  initial begin
    rst_n         = 1'b0;
    CE            = 1'b0;
    ROMINIT_ADDR  = '0;
    ROMINIT_DATA  = '0;
    ROMINIT_VALID = 1'b0;
    cfg_palette   = PALETTE_RGB;
    A             = '0;
    DB_I          = '0;
    RDB           = 1'b1;
    WRB           = 1'b1;
    CSB           = 1'b1;
    ce_seen       = 1'b0;
    cycles        = 0;
    frames_timed  = 0;
    rng_state     = 32'd65;
    load_stim();
    cycle_limit = run_budget();
    repeat (4) @(posedge CLK);
    rst_n <= 1'b1;
    for (int i = 0; i < cmds.size(); i++)
      run_cmd(cmds[i]);
    if (frames_timed == 0) begin
      report_failure("The timing monitor never saw a complete frame");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// File: tv1_stim.txt
# cmd addr count mode data, all hex; R rom fill, W write, B bgm write, Q read, P palette, F frame
# B and Q with mode 1 use xorshift bytes; F expects colour indexes data and mode inside DE
W 1403 1 0 A5
Q 1403 1 0 A5
W 1400 1 0 34
Q 1400 1 0 34
W 1400 1 0 00
Q 0800 1 0 00
B 1000 10 1 00
Q 1000 10 1 00
B 1000 200 0 00
Q 11FC 4 0 00
R 0000 0 0 00
W 1401 1 0 C6
W 1402 1 0 00
W 1400 1 0 01
F 0000 0 6 6
P 0000 0 1 00
F 0000 0 6 6
P 0000 0 0 00
W 1401 1 0 C3
W 1403 1 0 A3
W 1402 1 0 FF
F 0000 0 3 3
R 0000 0 0 FF
F 0000 0 A 3
W 1402 1 0 F0
F 0000 0 3 3
W 1400 1 0 41
F 0000 0 A 3

// File: vlog.f
+incdir+.
tv1_pkg.sv
tv1_video_counter.sv
tv1_cpu_bus.sv
tv1_bg_fetch.sv
tv1_bg_shifter.sv
tv1_top.sv
tb_tv1.sv

// File: Bender.yml
package:
  name: tv1_bg

sources:
  - files:
      - tv1_pkg.sv
      - tv1_video_counter.sv
      - tv1_cpu_bus.sv
      - tv1_bg_fetch.sv
      - tv1_bg_shifter.sv
      - tv1_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_tv1.sv
